//--- legv8Top.f
design/legv8Pkg.sv
design/ctrlIf.sv
design/cpuControl.sv
design/regFile.sv
design/alu.sv
design/condFlags.sv
design/execUnit.sv
design/pcUnit.sv
design/legv8Top.sv
verification/legv8Tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LEGv8 testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module legv8Tb \
	-f legv8Top.f \
	-o legv8Sim

./obj_dir/legv8Sim > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
	echo "run.sh: simulation reported success"
	exit 0
else
	echo "run.sh: simulation reported failure"
	exit 1
fi

//--- verification/legv8Tb.sv
/*
 * Random-instruction testbench for the single-cycle LEGv8 core.
 * An ISA-level model tracks registers, NZCV, PC and data memory; the
 * bench plays both memories and compares strobes, address, data and pc.
 */
module legv8Tb;
	import legv8Pkg::*;

	localparam logic [63:0] RESET_PC = 64'h0000_0000_0000_4000;
	localparam int PHASE_LEN = 400;
	localparam int CYCLE_LIMIT = 4 + 5 * PHASE_LEN + 100;

	// instruction kinds known to the model and the generator
	localparam int K_B = 0;
	localparam int K_BCOND = 1;
	localparam int K_BL = 2;
	localparam int K_BR = 3;
	localparam int K_CBZ = 4;
	localparam int K_ADDI = 5;
	localparam int K_ADDS = 6;
	localparam int K_SUBS = 7;
	localparam int K_LDUR = 8;
	localparam int K_STUR = 9;
	localparam int K_UNK = 10;

	logic        clk = 1'b0;
	logic        rst;
	logic [63:0] pc;
	logic [31:0] instr;
	logic [63:0] dataAddr;
	logic [63:0] dataWrData;
	logic        dataWrite;
	logic        dataRead;
	logic [63:0] dataRdData;

	// reference model state
	logic [63:0] mRegs [0:31];
	logic [63:0] mPc;
	logic        mN;
	logic        mZ;
	logic        mC;
	logic        mV;
	logic [63:0] dataMem [logic [63:0]];

	int  phaseChecks;
	int  phaseErrs;
	int  totalChecks;
	int  totalErrs;
	int  cycleCount;

	legv8Top #(
		.RESET_PC (RESET_PC)
	) UUT (
		.clk        (clk),
		.rst        (rst),
		.pc         (pc),
		.instr      (instr),
		.dataAddr   (dataAddr),
		.dataWrData (dataWrData),
		.dataWrite  (dataWrite),
		.dataRead   (dataRead),
		.dataRdData (dataRdData)
	);

	always #50 clk = ~clk;

	task automatic checkValue(input string name, input logic [63:0] expVal,
		input logic [63:0] actVal);
		phaseChecks++;
		assert (actVal === expVal) else begin
			$display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
			phaseErrs++;
		end
	endtask

	function automatic int decodeKind(input logic [31:0] w);
		int k;
		k = K_UNK;
		if (w[31:26] == OP_B) k = K_B;
		else if (w[31:24] == OP_BCOND) k = K_BCOND;
		else if (w[31:26] == OP_BL) k = K_BL;
		else if (w[31:21] == OP_BR) k = K_BR;
		else if (w[31:24] == OP_CBZ) k = K_CBZ;
		else if (w[31:22] == OP_ADDI) k = K_ADDI;
		else if (w[31:21] == OP_ADDS) k = K_ADDS;
		else if (w[31:21] == OP_LDUR) k = K_LDUR;
		else if (w[31:21] == OP_STUR) k = K_STUR;
		else if (w[31:21] == OP_SUBS) k = K_SUBS;
		return k;
	endfunction

	// XZR reads as zero
	function automatic logic [63:0] readReg(input logic [4:0] idx);
		return (idx == 5'd31) ? 64'd0 : mRegs[idx];
	endfunction

	task automatic writeReg(input logic [4:0] idx, input logic [63:0] val);
		if (idx != 5'd31) mRegs[idx] = val;
	endtask

	// base register plus sign-extended imm9
	function automatic logic [63:0] memAddr(input logic [31:0] w);
		return readReg(w[9:5]) + {{55{w[20]}}, w[20:12]};
	endfunction

	function automatic logic condHolds(input logic [3:0] c);
		logic r;
		case (c)
			4'd0: r = mZ;
			4'd1: r = !mZ;
			4'd2: r = mC;
			4'd3: r = !mC;
			4'd4: r = mN;
			4'd5: r = !mN;
			4'd6: r = mV;
			4'd7: r = !mV;
			4'd8: r = mC && !mZ;
			4'd9: r = !mC || mZ;
			4'd10: r = (mN == mV);
			4'd11: r = (mN != mV);
			4'd12: r = !mZ && (mN == mV);
			4'd13: r = mZ || (mN != mV);
			// AL and code 15 both mean always
			default: r = 1'b1;
		endcase
		return r;
	endfunction

	function automatic int pickKind(input int phase);
		int r;
		int k;
		r = int'($urandom_range(0, 99));
		case (phase)
			0: k = (r < 50) ? K_ADDI : (r < 75) ? K_STUR : K_UNK;
			1: k = (r < 30) ? K_ADDI : (r < 55) ? K_ADDS : (r < 80) ? K_SUBS
				: (r < 90) ? K_STUR : K_BCOND;
			2: k = (r < 15) ? K_ADDI : (r < 50) ? K_LDUR : (r < 85) ? K_STUR : K_ADDS;
			3: k = (r < 10) ? K_B : (r < 20) ? K_BL : (r < 30) ? K_BR
				: (r < 55) ? K_BCOND : (r < 70) ? K_CBZ : (r < 85) ? K_SUBS
				: (r < 95) ? K_ADDI : K_STUR;
			default: k = int'($urandom_range(0, 10));
		endcase
		return k;
	endfunction

	function automatic logic [31:0] makeWord(input int kind);
		logic [31:0] rnd;
		logic [31:0] w;
		logic [4:0]  rn;
		int          off;
		rnd = $urandom;
		off = int'($urandom_range(0, 32)) - 16;
		rn = rnd[9:5];
		case (kind)
			K_B: w = {OP_B, off[25:0]};
			K_BL: w = {OP_BL, off[25:0]};
			K_BCOND: w = {OP_BCOND, off[18:0], rnd[4:0]};
			// XZR half the time so that CBZ is taken now and then
			K_CBZ: w = {OP_CBZ, off[18:0], (rnd[30] ? 5'd31 : rnd[4:0])};
			K_BR: w = {OP_BR, rnd[20:10], (rnd[31] ? 5'd30 : rn), rnd[4:0]};
			K_ADDI: w = {OP_ADDI, rnd[21:10], rn, rnd[4:0]};
			K_ADDS: w = {OP_ADDS, rnd[20:10], rn, rnd[4:0]};
			K_SUBS: w = {OP_SUBS, rnd[20:10], rn, rnd[4:0]};
			// XZR base keeps addresses in a small window so stores and loads meet
			K_LDUR: w = {OP_LDUR, off[8:0], 2'b00, (rnd[31] ? 5'd31 : rn), rnd[4:0]};
			K_STUR: w = {OP_STUR, off[8:0], 2'b00, (rnd[31] ? 5'd31 : rn), rnd[4:0]};
			default: begin
				w = $urandom;
				while (decodeKind(w) != K_UNK) w = $urandom;
			end
		endcase
		return w;
	endfunction

	task automatic stepModel(input logic [31:0] w);
		int          kind;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] res;
		logic [63:0] nextPc;
		logic [64:0] wide;
		kind = decodeKind(w);
		nextPc = mPc + 64'd4;
		a = readReg(w[9:5]);
		b = readReg(w[20:16]);
		case (kind)
			K_B: nextPc = mPc + {{36{w[25]}}, w[25:0], 2'b00};
			K_BL: begin
				writeReg(5'd30, mPc + 64'd4);
				nextPc = mPc + {{36{w[25]}}, w[25:0], 2'b00};
			end
			K_BR: nextPc = a;
			K_BCOND: if (condHolds(w[3:0])) nextPc = mPc + {{43{w[23]}}, w[23:5], 2'b00};
			K_CBZ: if (readReg(w[4:0]) == 64'd0) nextPc = mPc + {{43{w[23]}}, w[23:5], 2'b00};
			K_ADDI: writeReg(w[4:0], a + {52'd0, w[21:10]});
			K_ADDS, K_SUBS: begin
				if (kind == K_ADDS) begin
					wide = {1'b0, a} + {1'b0, b};
					res = wide[63:0];
					mC = wide[64];
					mV = (a[63] == b[63]) && (res[63] != a[63]);
				end else begin
					res = a - b;
					// carry set when no borrow
					mC = (a >= b);
					mV = (a[63] != b[63]) && (res[63] != a[63]);
				end
				mN = res[63];
				mZ = (res == 64'd0);
				writeReg(w[4:0], res);
			end
			K_LDUR: writeReg(w[4:0], dataMem[memAddr(w)]);
			K_STUR: dataMem[memAddr(w)] = readReg(w[4:0]);
			default: ;
		endcase
		mPc = nextPc;
	endtask

	// one instruction, starting at a falling edge and ending at the next one
	task automatic runCycle(input int kind);
		logic [31:0] w;
		logic [63:0] addr;
		logic        expRead;
		logic        expWrite;
		int          wk;
		w = makeWord(kind);
		wk = decodeKind(w);
		addr = memAddr(w);
		expRead = rst && (wk == K_LDUR);
		expWrite = rst && (wk == K_STUR);
		instr = w;
		if (expRead) begin
			if (!dataMem.exists(addr)) dataMem[addr] = {$urandom, $urandom};
			dataRdData = dataMem[addr];
		end else begin
			dataRdData = {$urandom, $urandom};
		end
		#40;
		checkValue("dataRead", {63'd0, expRead}, {63'd0, dataRead});
		checkValue("dataWrite", {63'd0, expWrite}, {63'd0, dataWrite});
		if (expRead || expWrite) checkValue("dataAddr", addr, dataAddr);
		if (expWrite) checkValue("dataWrData", readReg(w[4:0]), dataWrData);
		if (rst) stepModel(w);
		@(negedge clk);
		checkValue("pc", mPc, pc);
	endtask

	function automatic string phaseName(input int p);
		case (p)
			0: return "reset";
			1: return "arithmetic";
			2: return "memory";
			3: return "branch";
			default: return "full mix";
		endcase
	endfunction

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		void'($urandom(32'h8d79_063a));
		rst = 1'b0;
		instr = 32'd0;
		dataRdData = 64'd0;
		mPc = RESET_PC;
		{mN, mZ, mC, mV} = 4'b0000;
		for (int i = 0; i < 32; i++) mRegs[i] = 64'd0;
		totalChecks = 0;
		totalErrs = 0;
		for (int p = 0; p < 5; p++) begin
			phaseChecks = 0;
			phaseErrs = 0;
			if (p == 0) begin
				// rst held low for 4 clock edges with random words on the bus
				repeat (4) runCycle(pickKind(4));
				rst = 1'b1;
			end
			for (int n = 0; n < PHASE_LEN; n++) runCycle(pickKind(p));
			$display("phase %0d %s: %0d checks, %0d errors", p, phaseName(p),
				phaseChecks, phaseErrs);
			totalChecks += phaseChecks;
			totalErrs += phaseErrs;
		end
		$display("Totals: %0d checks, %0d errors", totalChecks, totalErrs);
		if (totalErrs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- design/legv8Top.sv
/*
 * Single-cycle LEGv8 core. Instruction and data memory live outside and
 * must answer combinationally within the cycle.
 */
module legv8Top #(
	parameter logic [legv8Pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                       clk,
	input  logic                       rst,
	output logic [legv8Pkg::XLEN-1:0]  pc,
	input  logic [31:0]                instr,
	output logic [legv8Pkg::XLEN-1:0]  dataAddr,
	output logic [legv8Pkg::XLEN-1:0]  dataWrData,
	output logic                       dataWrite,
	output logic                       dataRead,
	input  logic [legv8Pkg::XLEN-1:0]  dataRdData
);
	import legv8Pkg::*;

	instrWord_t      instrWord;
	logic [4:0]      rdAddrA;
	logic [4:0]      rdAddrB;
	logic [4:0]      wrAddr;
	logic [XLEN-1:0] wrData;
	logic            wrEn;
	logic [XLEN-1:0] rdDataA;
	logic [XLEN-1:0] rdDataB;
	condCode_e       cond;
	flags_t          aluFlags;
	logic            aluZero;
	logic [XLEN-1:0] brTarget;
	logic            takeBranch;

	assign instrWord = instr;

	ctrlIf ctrlBus ();

	cpuControl controlInst (
		.instr (instrWord),
		.rst   (rst),
		.ctrl  (ctrlBus.control)
	);

	regFile regFileInst (
		.clk     (clk),
		.rst     (rst),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.wrEn    (wrEn),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB)
	);

	execUnit execInst (
		.ctrl       (ctrlBus.datapath),
		.instr      (instrWord),
		.pc         (pc),
		.rdAddrA    (rdAddrA),
		.rdAddrB    (rdAddrB),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.wrEn       (wrEn),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.dataAddr   (dataAddr),
		.dataWrData (dataWrData),
		.dataRead   (dataRead),
		.dataWrite  (dataWrite),
		.dataRdData (dataRdData),
		.cond       (cond),
		.aluFlags   (aluFlags),
		.aluZero    (aluZero),
		.brTarget   (brTarget)
	);

	condFlags flagsInst (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrlBus.datapath),
		.aluFlags   (aluFlags),
		.aluZero    (aluZero),
		.cond       (cond),
		.takeBranch (takeBranch)
	);

	pcUnit #(
		.RESET_PC (RESET_PC)
	) pcInst (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrlBus.datapath),
		.instr      (instrWord),
		.takeBranch (takeBranch),
		.brTarget   (brTarget),
		.pc         (pc)
	);

endmodule

//--- design/pcUnit.sv
/*
 * Program counter. Loads RESET_PC in reset and otherwise moves to the
 * BR target, a PC-relative branch target or the next sequential word.
 */
module pcUnit #(
	parameter logic [legv8Pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                       clk,
	input  logic                       rst,
	ctrlIf.datapath                    ctrl,
	input  legv8Pkg::instrWord_t       instr,
	input  logic                       takeBranch,
	input  logic [legv8Pkg::XLEN-1:0]  brTarget,
	output logic [legv8Pkg::XLEN-1:0]  pc
);
	import legv8Pkg::*;

	logic [XLEN-1:0] brOffset;
	logic [XLEN-1:0] pcNext;

	// word offsets, already scaled by 4
	assign brOffset = ctrl.uncondBr
		? {{(XLEN-28){instr.b.imm26[25]}}, instr.b.imm26, 2'b00}
		: {{(XLEN-21){instr.cb.imm19[18]}}, instr.cb.imm19, 2'b00};

	always_comb begin
		if (ctrl.branchReg) begin
			pcNext = brTarget;
		end else if (takeBranch) begin
			pcNext = pc + brOffset;
		end else begin
			pcNext = pc + 64'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

//--- design/execUnit.sv
/*
 * Datapath around the ALU. Selects register and immediate operands,
 * drives the data memory, and picks the write-back address and value.
 * Also hands the B.cond code, ALU flags and BR target to the branch logic.
 */
module execUnit (
	ctrlIf.datapath                    ctrl,
	input  legv8Pkg::instrWord_t       instr,
	input  logic [legv8Pkg::XLEN-1:0]  pc,
	output logic [4:0]                 rdAddrA,
	output logic [4:0]                 rdAddrB,
	output logic [4:0]                 wrAddr,
	output logic [legv8Pkg::XLEN-1:0]  wrData,
	output logic                       wrEn,
	input  logic [legv8Pkg::XLEN-1:0]  rdDataA,
	input  logic [legv8Pkg::XLEN-1:0]  rdDataB,
	output logic [legv8Pkg::XLEN-1:0]  dataAddr,
	output logic [legv8Pkg::XLEN-1:0]  dataWrData,
	output logic                       dataRead,
	output logic                       dataWrite,
	input  logic [legv8Pkg::XLEN-1:0]  dataRdData,
	output legv8Pkg::condCode_e        cond,
	output legv8Pkg::flags_t           aluFlags,
	output logic                       aluZero,
	output logic [legv8Pkg::XLEN-1:0]  brTarget
);
	import legv8Pkg::*;

	logic [XLEN-1:0] immExt;
	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluResult;

	// rn sits in the same bits for R, I and D formats
	assign rdAddrA = instr.r.rn;
	// rm for R format, rt for stores and CBZ
	assign rdAddrB = ctrl.reg2Loc ? instr.r.rm : instr.d.rt;

	// ADDI zero-extends imm12, loads and stores sign-extend imm9
	assign immExt = ctrl.immSel
		? {{(XLEN-12){1'b0}}, instr.i.imm12}
		: {{(XLEN-9){instr.d.imm9[8]}}, instr.d.imm9};
	assign aluB = ctrl.aluSrc ? immExt : rdDataB;

	alu aluInst (
		.a      (rdDataA),
		.b      (aluB),
		.op     (ctrl.aluOp),
		.result (aluResult),
		.flags  (aluFlags),
		.zero   (aluZero)
	);

	// data memory
	assign dataAddr   = aluResult;
	assign dataWrData = rdDataB;
	assign dataRead   = ctrl.memToReg;
	assign dataWrite  = ctrl.memWrite;

	// write-back, BL links into X30
	assign wrEn   = ctrl.regWrite;
	assign wrAddr = ctrl.branchLink ? 5'd30 : instr.r.rd;

	always_comb begin
		if (ctrl.branchLink) begin
			wrData = pc + 64'd4;
		end else if (ctrl.memToReg) begin
			wrData = dataRdData;
		end else begin
			wrData = aluResult;
		end
	end

	assign cond     = condCode_e'(instr.cb.rt[3:0]);
	assign brTarget = rdDataA;

endmodule

//--- design/condFlags.sv
/*
 * NZCV flag register and the branch-taken decision.
 * Flags load from the ALU on flag-setting instructions; B.cond reads the
 * stored copy, CBZ uses the live zero from the ALU.
 */
module condFlags (
	input  logic                 clk,
	input  logic                 rst,
	ctrlIf.datapath              ctrl,
	input  legv8Pkg::flags_t     aluFlags,
	input  logic                 aluZero,
	input  legv8Pkg::condCode_e  cond,
	output logic                 takeBranch
);
	import legv8Pkg::*;

	flags_t flagsQ;
	logic   condMet;

	always_ff @(posedge clk) begin
		if (!rst) begin
			flagsQ <= '0;
		end else if (ctrl.setFlags) begin
			flagsQ <= aluFlags;
		end
	end

	always_comb begin
		case (cond)
			EQ: condMet = flagsQ.z;
			NE: condMet = !flagsQ.z;
			HS: condMet = flagsQ.c;
			LO: condMet = !flagsQ.c;
			MI: condMet = flagsQ.n;
			PL: condMet = !flagsQ.n;
			VS: condMet = flagsQ.v;
			VC: condMet = !flagsQ.v;
			HI: condMet = flagsQ.c && !flagsQ.z;
			LS: condMet = !(flagsQ.c && !flagsQ.z);
			GE: condMet = (flagsQ.n == flagsQ.v);
			LT: condMet = (flagsQ.n != flagsQ.v);
			GT: condMet = !flagsQ.z && (flagsQ.n == flagsQ.v);
			LE: condMet = flagsQ.z || (flagsQ.n != flagsQ.v);
			// AL, and the unlisted code 15 which also means always
			default: condMet = 1'b1;
		endcase
	end

	assign takeBranch = ctrl.uncondBr
		|| (ctrl.condBr && condMet)
		|| (ctrl.zeroBr && aluZero);

endmodule

//--- design/alu.sv
/*
 * 64-bit ALU: add, subtract and pass-B.
 * Produces NZCV in ARM form; on subtract C is set when no borrow occurs.
 */
module alu (
	input  logic [legv8Pkg::XLEN-1:0]  a,
	input  logic [legv8Pkg::XLEN-1:0]  b,
	input  legv8Pkg::aluOp_e           op,
	output logic [legv8Pkg::XLEN-1:0]  result,
	output legv8Pkg::flags_t           flags,
	output logic                       zero
);
	import legv8Pkg::*;

	logic            isSub;
	logic [XLEN-1:0] bOperand;
	logic [XLEN:0]   sum;
	logic            overflow;

	// subtract as a + ~b + 1
	assign isSub    = (op == ALU_SUB);
	assign bOperand = isSub ? ~b : b;
	assign sum      = {1'b0, a} + {1'b0, bOperand} + {{XLEN{1'b0}}, isSub};

	// operands agree in sign but the sum does not
	assign overflow = (a[XLEN-1] == bOperand[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);

	assign result = (op == ALU_PASSB) ? b : sum[XLEN-1:0];
	assign zero   = (result == '0);

	always_comb begin
		flags.n = result[XLEN-1];
		flags.z = zero;
		flags.c = (op == ALU_PASSB) ? 1'b0 : sum[XLEN];
		flags.v = (op == ALU_PASSB) ? 1'b0 : overflow;
	end

endmodule

//--- design/regFile.sv
/*
 * 32 x 64 register file, two combinational reads and one write per clock.
 * X31 is XZR: it reads as zero and writes to it are dropped.
 */
module regFile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [4:0]                 rdAddrA,
	input  logic [4:0]                 rdAddrB,
	input  logic [4:0]                 wrAddr,
	input  logic [legv8Pkg::XLEN-1:0]  wrData,
	input  logic                       wrEn,
	output logic [legv8Pkg::XLEN-1:0]  rdDataA,
	output logic [legv8Pkg::XLEN-1:0]  rdDataB
);
	import legv8Pkg::*;

	// only X0..X30 need storage
	logic [XLEN-1:0] regs [0:30];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 31; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != 5'd31)) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = (rdAddrA == 5'd31) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == 5'd31) ? '0 : regs[rdAddrB];

endmodule

//--- design/cpuControl.sv
/*
 * Main opcode decoder. Compares the opcode slices of each format in a
 * fixed priority and drives the control bundle. Unknown opcodes and
 * reset both produce an inactive bundle, so nothing is written.
 */
module cpuControl (
	input  legv8Pkg::instrWord_t instr,
	input  logic                 rst,
	ctrlIf.control               ctrl
);
	import legv8Pkg::*;

	always_comb begin
		// everything inactive unless an opcode below matches
		ctrl.uncondBr   = 1'b0;
		ctrl.condBr     = 1'b0;
		ctrl.zeroBr     = 1'b0;
		ctrl.branchReg  = 1'b0;
		ctrl.branchLink = 1'b0;
		ctrl.reg2Loc    = 1'b0;
		ctrl.aluSrc     = 1'b0;
		ctrl.immSel     = 1'b0;
		ctrl.aluOp      = ALU_ADD;
		ctrl.setFlags   = 1'b0;
		ctrl.regWrite   = 1'b0;
		ctrl.memToReg   = 1'b0;
		ctrl.memWrite   = 1'b0;

		if (!rst) begin
			// held inactive through reset
		end else if (instr.b.opcode == OP_B) begin
			ctrl.uncondBr = 1'b1;
		end else if (instr.cb.opcode == OP_BCOND) begin
			ctrl.condBr = 1'b1;
		end else if (instr.b.opcode == OP_BL) begin
			ctrl.uncondBr   = 1'b1;
			ctrl.branchLink = 1'b1;
			ctrl.regWrite   = 1'b1;
		end else if (instr.r.opcode == OP_BR) begin
			ctrl.uncondBr  = 1'b1;
			ctrl.branchReg = 1'b1;
		end else if (instr.cb.opcode == OP_CBZ) begin
			// rt goes through the ALU untouched to test for zero
			ctrl.zeroBr = 1'b1;
			ctrl.aluOp  = ALU_PASSB;
		end else if (instr.i.opcode == OP_ADDI) begin
			ctrl.aluSrc   = 1'b1;
			ctrl.immSel   = 1'b1;
			ctrl.regWrite = 1'b1;
		end else if (instr.r.opcode == OP_ADDS) begin
			ctrl.reg2Loc  = 1'b1;
			ctrl.setFlags = 1'b1;
			ctrl.regWrite = 1'b1;
		end else if (instr.d.opcode == OP_LDUR) begin
			ctrl.aluSrc   = 1'b1;
			ctrl.regWrite = 1'b1;
			ctrl.memToReg = 1'b1;
		end else if (instr.d.opcode == OP_STUR) begin
			ctrl.aluSrc   = 1'b1;
			ctrl.memWrite = 1'b1;
		end else if (instr.r.opcode == OP_SUBS) begin
			ctrl.reg2Loc  = 1'b1;
			ctrl.aluOp    = ALU_SUB;
			ctrl.setFlags = 1'b1;
			ctrl.regWrite = 1'b1;
		end
	end

endmodule

//--- design/ctrlIf.sv
/*
 * Decoded control bundle for one instruction.
 * The decoder drives it; datapath blocks only read it.
 */
interface ctrlIf;
	import legv8Pkg::*;

	// branch kinds
	logic uncondBr;
	logic condBr;
	logic zeroBr;
	logic branchReg;
	logic branchLink;

	// operand and ALU control
	logic   reg2Loc;
	logic   aluSrc;
	logic   immSel;
	aluOp_e aluOp;
	logic   setFlags;

	// write-back and memory
	logic regWrite;
	logic memToReg;
	logic memWrite;

	modport control (
		output uncondBr, condBr, zeroBr, branchReg, branchLink,
		output reg2Loc, aluSrc, immSel, aluOp, setFlags,
		output regWrite, memToReg, memWrite
	);

	modport datapath (
		input uncondBr, condBr, zeroBr, branchReg, branchLink,
		input reg2Loc, aluSrc, immSel, aluOp, setFlags,
		input regWrite, memToReg, memWrite
	);

endinterface

//--- design/legv8Pkg.sv
/*
 * Shared types and constants for the single-cycle LEGv8 core.
 * Holds the instruction formats, the ALU and condition encodings and the
 * opcode values that the decoder compares against.
 */
package legv8Pkg;

	localparam int XLEN = 64;

	typedef struct packed {
		logic [10:0] opcode;
		logic [4:0]  rm;
		logic [5:0]  shamt;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} rFormat_t;

	typedef struct packed {
		logic [9:0]  opcode;
		logic [11:0] imm12;
		logic [4:0]  rn;
		logic [4:0]  rd;
	} iFormat_t;

	typedef struct packed {
		logic [10:0] opcode;
		logic [8:0]  imm9;
		logic [1:0]  op2;
		logic [4:0]  rn;
		logic [4:0]  rt;
	} dFormat_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] imm26;
	} bFormat_t;

	// low 4 bits of rt carry the condition for B.cond
	typedef struct packed {
		logic [7:0]  opcode;
		logic [18:0] imm19;
		logic [4:0]  rt;
	} cbFormat_t;

	// one fetched word, read as whichever format the opcode selects
	typedef union packed {
		rFormat_t  r;
		iFormat_t  i;
		dFormat_t  d;
		bFormat_t  b;
		cbFormat_t cb;
	} instrWord_t;

	typedef enum logic [1:0] {
		ALU_ADD   = 2'd0,
		ALU_SUB   = 2'd1,
		ALU_PASSB = 2'd2
	} aluOp_e;

	typedef enum logic [3:0] {
		EQ = 4'd0,  NE = 4'd1,  HS = 4'd2,  LO = 4'd3,
		MI = 4'd4,  PL = 4'd5,  VS = 4'd6,  VC = 4'd7,
		HI = 4'd8,  LS = 4'd9,  GE = 4'd10, LT = 4'd11,
		GT = 4'd12, LE = 4'd13, AL = 4'd14
	} condCode_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	// opcode fields, each as wide as its format's slice
	localparam logic [5:0]  OP_B     = 6'b000101;
	localparam logic [7:0]  OP_BCOND = 8'b01010100;
	localparam logic [5:0]  OP_BL    = 6'b100101;
	localparam logic [10:0] OP_BR    = 11'b11010110000;
	localparam logic [7:0]  OP_CBZ   = 8'b10110100;
	localparam logic [9:0]  OP_ADDI  = 10'b1001000100;
	localparam logic [10:0] OP_ADDS  = 11'b10101011000;
	localparam logic [10:0] OP_SUBS  = 11'b11101011000;
	localparam logic [10:0] OP_LDUR  = 11'b11111000010;
	localparam logic [10:0] OP_STUR  = 11'b11111000000;

endpackage
